// ==== memPkg.sv ====
package memPkg;

	// ------------------------------------------------------------------------
	// Memory map
	// ------------------------------------------------------------------------

	localparam int PAGE_BITS      = 8;   // Page number is the top of a CPU address
	localparam int CPU_ADDR_BITS  = 22;
	localparam int SDR_ADDR_BITS  = 24;
	localparam int BOOT_ADDR_BITS = 17;  // Default boot image, 128 KB
	localparam int RAM_SIZE_BITS  = 3;

	localparam logic [PAGE_BITS-1:0] VMM_FIRST_PAGE    = 8'hFC;
	localparam logic [PAGE_BITS-1:0] ROM_WRITABLE_PAGE = 8'h07; // Upper half only

	// ------------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------------

	localparam int AXI_ADDR_BITS = 4;
	localparam int AXI_DATA_BITS = 32;

	localparam logic [AXI_ADDR_BITS-1:0] REG_CTRL   = 4'h0;
	localparam logic [AXI_ADDR_BITS-1:0] REG_STATUS = 4'h4; // Read only

	localparam int CTRL_SPEED_BIT    = 4;
	localparam int CTRL_SOFT_RST_BIT = 8;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ------------------------------------------------------------------------
	// Bundles
	// ------------------------------------------------------------------------

	typedef struct packed {
		logic [RAM_SIZE_BITS-1:0] ramSize;
		logic                     speed;     // 0 is 4 MHz, 1 is 8 MHz
		logic                     softReset;
	} memConfig_t;

	typedef struct packed {
		logic                     rd;
		logic                     wr;
		logic [CPU_ADDR_BITS-1:0] addr;
		logic [7:0]               data;
	} cpuBus_t;

	typedef struct packed {
		logic                     rfsh;
		logic                     rd;
		logic                     wr;
		logic [SDR_ADDR_BITS-1:0] addr;
		logic [7:0]               data;
	} sdrReq_t;

	typedef struct packed {
		logic                     active;
		logic                     wr;
		logic [CPU_ADDR_BITS-1:0] addr;
		logic [7:0]               data;
	} download_t;

	typedef struct packed {
		logic vmm;
		logic ram;
		logic rom;
		logic readable;
		logic writable;
	} pageClass_t;

	// First RAM page for each size code, RAM runs from there up to FF
	function automatic logic [PAGE_BITS-1:0] firstRamPage(input logic [RAM_SIZE_BITS-1:0] code);
		case (code)
			3'd1:    return 8'h80; // 2 MB
			3'd2:    return 8'h40; // 3 MB
			3'd3:    return 8'hFC; // 64 KB
			3'd4:    return 8'hF8; // 128 KB
			3'd5:    return 8'hF0; // 256 KB
			3'd6:    return 8'hE0; // 512 KB
			default: return 8'hC0; // 1 MB, codes 0 and 7
		endcase
	endfunction

endpackage

// ==== memConfigRegs.sv ====
module memConfigRegs import memPkg::*; (
	input  logic                     clock32,
	input  logic                     power,

	input  logic                     awValid_i,
	output logic                     awReady_o,
	input  logic [AXI_ADDR_BITS-1:0] awAddr_i,
	input  logic                     wValid_i,
	output logic                     wReady_o,
	input  logic [AXI_DATA_BITS-1:0] wData_i,
	input  logic [AXI_DATA_BITS/8-1:0] wStrb_i,
	output logic                     bValid_o,
	input  logic                     bReady_i,
	output logic [1:0]               bResp_o,
	input  logic                     arValid_i,
	output logic                     arReady_o,
	input  logic [AXI_ADDR_BITS-1:0] arAddr_i,
	output logic                     rValid_o,
	input  logic                     rReady_i,
	output logic [AXI_DATA_BITS-1:0] rData_o,
	output logic [1:0]               rResp_o,

	output memConfig_t               config_o,
	input  logic                     sdrReady_i,
	input  logic                     initDone_i,
	input  logic                     downloadActive_i,
	input  logic [PAGE_BITS-1:0]     romTopPage_i,
	output logic                     cpuReset_o
);

	logic awHeld, wHeld;
	logic awFire, wFire, arFire, writeGo;
	logic [AXI_ADDR_BITS-1:0] awAddrQ;
	logic [AXI_DATA_BITS-1:0] wDataQ;
	logic [AXI_DATA_BITS/8-1:0] wStrbQ;
	logic [AXI_DATA_BITS-1:0] ctrlWord, statusWord;

	// One write in flight, so both channels stall until B is taken
	assign awReady_o = !awHeld && !bValid_o;
	assign wReady_o  = !wHeld && !bValid_o;
	assign arReady_o = !rValid_o;

	assign awFire  = awValid_i && awReady_o;
	assign wFire   = wValid_i && wReady_o;
	assign arFire  = arValid_i && arReady_o;
	assign writeGo = awHeld && wHeld;

	assign ctrlWord = {{(AXI_DATA_BITS-9){1'b0}}, config_o.softReset, 3'd0,
		config_o.speed, 1'b0, config_o.ramSize};
	assign statusWord = {{(AXI_DATA_BITS-16){1'b0}}, romTopPage_i, 5'd0,
		downloadActive_i, initDone_i, sdrReady_i};

	// ------------------------------------------------------------------------
	// Write channel
	// ------------------------------------------------------------------------

	always_ff @(posedge clock32) begin
		if (awFire) awAddrQ <= awAddr_i;
		if (wFire) begin
			wDataQ <= wData_i;
			wStrbQ <= wStrb_i;
		end
	end

	always_ff @(posedge clock32, negedge power) begin
		if (!power) begin
			awHeld   <= 1'b0;
			wHeld    <= 1'b0;
			bValid_o <= 1'b0;
			bResp_o  <= RESP_OKAY;
			config_o <= '0; // 1 MB, 4 MHz
		end else begin
			if (awFire) awHeld <= 1'b1;
			if (wFire) wHeld <= 1'b1;

			if (writeGo) begin
				awHeld   <= 1'b0;
				wHeld    <= 1'b0;
				bValid_o <= 1'b1;
				if (awAddrQ == REG_CTRL) begin
					if (wStrbQ[0]) begin
						config_o.ramSize <= wDataQ[RAM_SIZE_BITS-1:0];
						config_o.speed   <= wDataQ[CTRL_SPEED_BIT];
					end
					if (wStrbQ[1]) config_o.softReset <= wDataQ[CTRL_SOFT_RST_BIT];
					bResp_o <= RESP_OKAY;
				end else begin
					bResp_o <= RESP_SLVERR; // STATUS is read only, rest unmapped
				end
			end else if (bValid_o && bReady_i) begin
				bValid_o <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Read channel
	// ------------------------------------------------------------------------

	always_ff @(posedge clock32) begin
		if (arFire) begin
			case (arAddr_i)
				REG_CTRL:   rData_o <= ctrlWord;
				REG_STATUS: rData_o <= statusWord;
				default:    rData_o <= '0;
			endcase
		end
	end

	always_ff @(posedge clock32, negedge power) begin
		if (!power) begin
			rValid_o <= 1'b0;
			rResp_o  <= RESP_OKAY;
		end else if (arFire) begin
			rValid_o <= 1'b1;
			rResp_o  <= (arAddr_i == REG_CTRL || arAddr_i == REG_STATUS) ? RESP_OKAY : RESP_SLVERR;
		end else if (rValid_o && rReady_i) begin
			rValid_o <= 1'b0;
		end
	end

	// CPU held in reset until memory is settled
	always_ff @(posedge clock32, negedge power) begin
		if (!power) cpuReset_o <= 1'b1;
		else cpuReset_o <= !(sdrReady_i && initDone_i && !downloadActive_i && !config_o.softReset);
	end

	bRiseAfterWrite: assert property (@(posedge clock32) disable iff (!power)
		$rose(bValid_o) |-> $past(awHeld && wHeld))
		else $error("BVALID rose without a completed AW and W handshake");

	rHoldUntilReady: assert property (@(posedge clock32) disable iff (!power)
		rValid_o && !rReady_i |=> rValid_o)
		else $error("RVALID dropped before RREADY");

endmodule

// ==== pageDecoder.sv ====
module pageDecoder import memPkg::*; (
	input  logic                 clock32,
	input  logic                 power,
	input  cpuBus_t              cpuBus_i,
	input  download_t            download_i,
	input  memConfig_t           config_i,
	output pageClass_t           class_o,
	output logic [PAGE_BITS-1:0] romTopPage_o,
	input  logic [7:0]           sdrQ_i,
	output logic [7:0]           cpuRdData_o
);

	logic [PAGE_BITS-1:0] page;
	logic lastReadable; // Class of the last CPU read, held while data returns

	assign page = cpuBus_i.addr[CPU_ADDR_BITS-1 -: PAGE_BITS];

	// Highest ROM page seen in the download, 16 KB per page
	always_ff @(posedge clock32, negedge power) begin
		if (!power) romTopPage_o <= 8'd7;
		else if (download_i.active && download_i.wr)
			romTopPage_o <= {{(PAGE_BITS-3){1'b0}}, download_i.addr[16:14]};
	end

	always_comb begin
		class_o.vmm      = page >= VMM_FIRST_PAGE;
		class_o.ram      = page >= firstRamPage(config_i.ramSize);
		class_o.rom      = page <= romTopPage_o;
		class_o.readable = class_o.ram || class_o.rom;
		class_o.writable = class_o.ram
			|| (page == ROM_WRITABLE_PAGE && cpuBus_i.addr[13]); // Upper 8 KB of page 07
	end

	always_ff @(posedge clock32, negedge power) begin
		if (!power) lastReadable <= 1'b0;
		else if (cpuBus_i.rd) lastReadable <= class_o.readable;
	end

	// Unpopulated pages float high
	assign cpuRdData_o = lastReadable ? sdrQ_i : 8'hFF;

	// Video sits inside every RAM size and above any ROM page
	vmmIsRam: assert property (@(posedge clock32) disable iff (!power)
		class_o.vmm |-> class_o.ram && class_o.readable && !class_o.rom)
		else $error("Video page not classified as readable RAM");

endmodule

// ==== initLoader.sv ====
module initLoader import memPkg::*; #(
	parameter int BootAddrBits = BOOT_ADDR_BITS
) (
	input  logic                    clock32,
	input  logic                    power,
	input  logic                    sdrReady_i,
	output logic [BootAddrBits-1:0] bootAddr_o,
	input  logic [7:0]              bootData_i,
	output sdrReq_t                 loadReq_o,
	output logic                    initDone_o
);

	// Top bit is the done flag, bit 0 the phase, the rest the address
	logic [BootAddrBits+1:0] count;
	logic phase;

	assign initDone_o = count[BootAddrBits+1];
	assign bootAddr_o = count[BootAddrBits:1];
	assign phase      = count[0];

	always_ff @(posedge clock32, negedge power) begin
		if (!power) count <= '0;
		else if (sdrReady_i && !initDone_o) count <= count + 1'b1;
	end

	// Odd phase, boot data for this address has arrived
	always_comb begin
		loadReq_o.rfsh = 1'b1;
		loadReq_o.rd   = 1'b0;
		loadReq_o.wr   = phase && !initDone_o;
		loadReq_o.addr = {{(SDR_ADDR_BITS-BootAddrBits){1'b0}}, bootAddr_o};
		loadReq_o.data = bootData_i;
	end

endmodule

// ==== memArbiter.sv ====
module memArbiter import memPkg::*; (
	input  logic       clock32,
	input  logic       power,
	input  sdrReq_t    loadReq_i,
	input  logic       initDone_i,
	input  download_t  download_i,
	input  cpuBus_t    cpuBus_i,
	input  logic       cpuRfsh_i,
	input  pageClass_t class_i,
	output sdrReq_t    sdrReq_o,
	output logic       vmmWr_o
);

	sdrReq_t nextReq;
	logic nextVmmWr;
	logic cpuOwns;

	assign cpuOwns = initDone_i && !download_i.active;

	// ------------------------------------------------------------------------
	// Priority: loader, then download, then CPU
	// ------------------------------------------------------------------------

	always_comb begin
		nextReq.rfsh = cpuRfsh_i;
		nextReq.rd   = 1'b0;
		nextReq.wr   = 1'b0;
		nextReq.addr = {{(SDR_ADDR_BITS-CPU_ADDR_BITS){1'b0}}, cpuBus_i.addr};
		nextReq.data = cpuBus_i.data;

		if (!initDone_i) begin
			nextReq = loadReq_i; // Refresh forced by the loader
		end else if (download_i.active) begin
			nextReq.wr   = download_i.wr;
			nextReq.addr = {{(SDR_ADDR_BITS-CPU_ADDR_BITS){1'b0}}, download_i.addr};
			nextReq.data = download_i.data;
		end else begin
			nextReq.rd = cpuBus_i.rd && class_i.readable;
			nextReq.wr = cpuBus_i.wr && class_i.writable;
		end
	end

	// Video RAM is written alongside SDRAM
	assign nextVmmWr = cpuOwns && cpuBus_i.wr && class_i.vmm;

	always_ff @(posedge clock32, negedge power) begin
		if (!power) begin
			sdrReq_o      <= '0;
			sdrReq_o.rfsh <= 1'b1;
			vmmWr_o       <= 1'b0;
		end else begin
			sdrReq_o <= nextReq;
			vmmWr_o  <= nextVmmWr;
		end
	end

	oneStrobe: assert property (@(posedge clock32) disable iff (!power)
		!(sdrReq_o.rd && sdrReq_o.wr))
		else $error("SDRAM request carries rd and wr together");

endmodule

// ==== memSubsystem.sv ====
module memSubsystem import memPkg::*; #(
	parameter int BootAddrBits = BOOT_ADDR_BITS
) (
	input  logic                       clock32,
	input  logic                       power,

	input  logic                       awValid_i,
	output logic                       awReady_o,
	input  logic [AXI_ADDR_BITS-1:0]   awAddr_i,
	input  logic                       wValid_i,
	output logic                       wReady_o,
	input  logic [AXI_DATA_BITS-1:0]   wData_i,
	input  logic [AXI_DATA_BITS/8-1:0] wStrb_i,
	output logic                       bValid_o,
	input  logic                       bReady_i,
	output logic [1:0]                 bResp_o,
	input  logic                       arValid_i,
	output logic                       arReady_o,
	input  logic [AXI_ADDR_BITS-1:0]   arAddr_i,
	output logic                       rValid_o,
	input  logic                       rReady_i,
	output logic [AXI_DATA_BITS-1:0]   rData_o,
	output logic [1:0]                 rResp_o,

	input  cpuBus_t                    cpuBus_i,
	input  logic                       cpuRfsh_i,
	output logic [7:0]                 cpuRdData_o,
	output logic                       cpuReset_o,
	output logic                       cpuSpeed_o,

	input  download_t                  download_i,

	output logic [BootAddrBits-1:0]    bootAddr_o,
	input  logic [7:0]                 bootData_i,

	input  logic                       sdrReady_i,
	output sdrReq_t                    sdrReq_o,
	input  logic [7:0]                 sdrQ_i,

	output logic                       vmmWr_o
);

	memConfig_t           memConfig;
	pageClass_t           pageClass;
	sdrReq_t              loadReq;
	logic [PAGE_BITS-1:0] romTopPage;
	logic                 initDone;

	assign cpuSpeed_o = memConfig.speed;

	memConfigRegs uRegs (
		.clock32(clock32), .power(power),
		.awValid_i(awValid_i), .awReady_o(awReady_o), .awAddr_i(awAddr_i),
		.wValid_i(wValid_i), .wReady_o(wReady_o), .wData_i(wData_i), .wStrb_i(wStrb_i),
		.bValid_o(bValid_o), .bReady_i(bReady_i), .bResp_o(bResp_o),
		.arValid_i(arValid_i), .arReady_o(arReady_o), .arAddr_i(arAddr_i),
		.rValid_o(rValid_o), .rReady_i(rReady_i), .rData_o(rData_o), .rResp_o(rResp_o),
		.config_o(memConfig), .sdrReady_i(sdrReady_i), .initDone_i(initDone),
		.downloadActive_i(download_i.active), .romTopPage_i(romTopPage),
		.cpuReset_o(cpuReset_o)
	);

	pageDecoder uDecoder (
		.clock32(clock32), .power(power), .cpuBus_i(cpuBus_i), .download_i(download_i),
		.config_i(memConfig), .class_o(pageClass), .romTopPage_o(romTopPage),
		.sdrQ_i(sdrQ_i), .cpuRdData_o(cpuRdData_o)
	);

	initLoader #(.BootAddrBits(BootAddrBits)) uLoader (
		.clock32(clock32), .power(power), .sdrReady_i(sdrReady_i),
		.bootAddr_o(bootAddr_o), .bootData_i(bootData_i),
		.loadReq_o(loadReq), .initDone_o(initDone)
	);

	memArbiter uArbiter (
		.clock32(clock32), .power(power), .loadReq_i(loadReq), .initDone_i(initDone),
		.download_i(download_i), .cpuBus_i(cpuBus_i), .cpuRfsh_i(cpuRfsh_i),
		.class_i(pageClass), .sdrReq_o(sdrReq_o), .vmmWr_o(vmmWr_o)
	);

endmodule

// ==== tbClock.sv ====
module tbClock (
	output logic clock32_o,
	output logic power_o
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock32_o = 1'b0;
		forever #2 clock32_o = !clock32_o; // 4 ns period
	end

	// Power reset held low for 5 cycles
	initial begin
		power_o = 1'b0;
		repeat (5) @(posedge clock32_o);
		@(negedge clock32_o);
		power_o = 1'b1;
	end

endmodule

// ==== tbMemSubsystem.sv ====
module tbMemSubsystem import memPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int BootBits = 5;
	localparam int Watchdog = 3 * (64 + 400); // Cycles

	logic clock32, power;
	logic awValid, awReady, wValid, wReady, bValid, bReady;
	logic arValid, arReady, rValid, rReady;
	logic [AXI_ADDR_BITS-1:0] awAddr, arAddr;
	logic [AXI_DATA_BITS-1:0] wData, rData;
	logic [3:0] wStrb;
	logic [1:0] bResp, rResp;
	cpuBus_t cpuBus;
	download_t download;
	sdrReq_t sdrReq;
	logic cpuRfsh, cpuReset, cpuSpeed, vmmWr, sdrReady;
	logic [7:0] cpuRdData, bootData, sdrQ;
	logic [BootBits-1:0] bootAddr;

	int valueErrors = 0;
	int otherErrors = 0;
	logic [31:0] rngState = 32'd20;

	tbClock uClock (.clock32_o(clock32), .power_o(power));

	memSubsystem #(.BootAddrBits(BootBits)) DUT (
		.clock32(clock32), .power(power),
		.awValid_i(awValid), .awReady_o(awReady), .awAddr_i(awAddr),
		.wValid_i(wValid), .wReady_o(wReady), .wData_i(wData), .wStrb_i(wStrb),
		.bValid_o(bValid), .bReady_i(bReady), .bResp_o(bResp),
		.arValid_i(arValid), .arReady_o(arReady), .arAddr_i(arAddr),
		.rValid_o(rValid), .rReady_i(rReady), .rData_o(rData), .rResp_o(rResp),
		.cpuBus_i(cpuBus), .cpuRfsh_i(cpuRfsh), .cpuRdData_o(cpuRdData),
		.cpuReset_o(cpuReset), .cpuSpeed_o(cpuSpeed), .download_i(download),
		.bootAddr_o(bootAddr), .bootData_i(bootData),
		.sdrReady_i(sdrReady), .sdrReq_o(sdrReq), .sdrQ_i(sdrQ), .vmmWr_o(vmmWr)
	);

	// ------------------------------------------------------------------------
	// Memory models
	// ------------------------------------------------------------------------

	logic [7:0] sdrMem [logic [23:0]];
	logic rdStage;
	logic [23:0] addrStage;

	function automatic logic [7:0] readMem(input logic [23:0] addr);
		if (sdrMem.exists(addr)) return sdrMem[addr];
		return 8'h00;
	endfunction

	always @(posedge clock32) begin
		if (sdrReq.wr) sdrMem[sdrReq.addr] = sdrReq.data;
		rdStage   <= sdrReq.rd; // Two cycle read latency
		addrStage <= sdrReq.addr;
		if (rdStage) sdrQ <= readMem(addrStage);
	end

	always @(posedge clock32) bootData <= {3'b000, bootAddr} ^ 8'hA5; // Boot ROM

	// ------------------------------------------------------------------------
	// Checks and helpers
	// ------------------------------------------------------------------------

	downloadHoldsReset: assert property (@(posedge clock32) disable iff (!power)
		download.active |=> cpuReset)
		else begin
			otherErrors++;
			$display("ERROR %0t ns CPU left reset while a download was active", $time);
		end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic logic [13:0] randomOffset();
		logic [31:0] r;
		r = nextRandom();
		return r[13:0];
	endfunction

	function automatic logic [7:0] randomByte();
		logic [31:0] r;
		r = nextRandom();
		return r[7:0];
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			valueErrors++;
			$display("FAIL %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic reportProblem(input string msg);
		otherErrors++;
		$display("ERROR %0t ns %s", $time, msg);
	endtask

	task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
		input logic [1:0] expResp);
		bit awDone, wDone;
		int waitCount;
		awDone = 0;
		wDone = 0;
		waitCount = 0;
		awValid = 1'b1;
		awAddr = addr;
		wValid = 1'b1;
		wData = data;
		wStrb = 4'hF;
		while (!(awDone && wDone) && waitCount < 20) begin
			if (awValid && awReady) awDone = 1; // Fires at the coming rising edge
			if (wValid && wReady) wDone = 1;
			@(negedge clock32);
			if (awDone) awValid = 1'b0;
			if (wDone) wValid = 1'b0;
			waitCount++;
		end
		while (!bValid && waitCount < 20) begin
			@(negedge clock32);
			waitCount++;
		end
		if (!bValid) reportProblem("AXI write response never arrived");
		else checkValue("bResp_o", expResp, bResp);
		@(negedge clock32); // bReady is held high
	endtask

	task automatic axiRead(input logic [3:0] addr, input logic [31:0] expData,
		input logic [1:0] expResp);
		int waitCount;
		waitCount = 0;
		rReady = 1'b0;
		arValid = 1'b1;
		arAddr = addr;
		while (arValid && waitCount < 20) begin
			if (arReady) begin
				@(negedge clock32);
				arValid = 1'b0;
			end else begin
				@(negedge clock32);
			end
			waitCount++;
		end
		while (!rValid && waitCount < 20) begin
			@(negedge clock32);
			waitCount++;
		end
		if (!rValid) begin
			reportProblem("AXI read data never arrived");
		end else begin
			checkValue("rResp_o", expResp, rResp);
			checkValue("rData_o", expData, rData);
		end
		@(negedge clock32); // RVALID has to wait for RREADY
		rReady = 1'b1;
		@(negedge clock32);
	endtask

	task automatic waitReset(input logic level);
		int waitCount;
		waitCount = 0;
		while (cpuReset !== level && waitCount < 10) begin
			@(negedge clock32);
			waitCount++;
		end
		if (cpuReset !== level) reportProblem($sformatf("cpuReset_o never went to %0d", level));
	endtask

	task automatic checkBoot();
		int writes [32];
		int cycles;
		foreach (writes[i]) writes[i] = 0;
		cycles = 0;
		while (cpuReset && cycles < 2 * 32 + 20) begin
			@(negedge clock32);
			cycles++;
			if (sdrReq.rd) reportProblem("SDRAM read issued during the boot copy");
			if (sdrReq.wr) begin
				checkValue("sdrReq_o.rfsh", 1, sdrReq.rfsh);
				if (sdrReq.addr < 32) begin
					writes[sdrReq.addr[4:0]]++;
					checkValue("sdrReq_o.data", {3'b000, sdrReq.addr[4:0]} ^ 8'hA5, sdrReq.data);
				end else begin
					reportProblem("boot write landed outside the image");
				end
			end
		end
		if (cpuReset) reportProblem("cpuReset_o stayed high after the boot copy");
		foreach (writes[i])
			if (writes[i] != 1)
				reportProblem($sformatf("boot address %0d written %0d times", i, writes[i]));
	endtask

	task automatic cpuRead(input logic [21:0] addr, input bit forwarded,
		input logic [7:0] expected);
		cpuBus.rd = 1'b1;
		cpuBus.addr = addr;
		@(negedge clock32);
		cpuBus.rd = 1'b0;
		checkValue("sdrReq_o.rd", forwarded, sdrReq.rd);
		if (forwarded) checkValue("sdrReq_o.addr", addr, sdrReq.addr);
		repeat (2) @(negedge clock32);
		checkValue("cpuRdData_o", expected, cpuRdData);
	endtask

	task automatic cpuWrite(input logic [21:0] addr, input logic [7:0] data,
		input bit forwarded, input bit video);
		cpuBus.wr = 1'b1;
		cpuBus.addr = addr;
		cpuBus.data = data;
		@(negedge clock32);
		cpuBus.wr = 1'b0;
		checkValue("sdrReq_o.wr", forwarded, sdrReq.wr);
		if (forwarded) begin
			checkValue("sdrReq_o.addr", addr, sdrReq.addr);
			checkValue("sdrReq_o.data", data, sdrReq.data);
		end
		checkValue("vmmWr_o", video, vmmWr);
		@(negedge clock32);
		checkValue("vmmWr_o", 0, vmmWr); // Single pulse
	endtask

	task automatic downloadByte(input logic [21:0] addr, input logic [7:0] data);
		download.wr = 1'b1;
		download.addr = addr;
		download.data = data;
		@(negedge clock32);
		download.wr = 1'b0;
		checkValue("sdrReq_o.wr", 1, sdrReq.wr);
		checkValue("sdrReq_o.addr", addr, sdrReq.addr);
		checkValue("sdrReq_o.data", data, sdrReq.data);
		checkValue("cpuReset_o", 1, cpuReset);
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		logic [13:0] offs;
		logic [7:0] value;
		logic [21:0] page2Addr;
		logic [7:0] page2Data;

		awValid = 1'b0;
		awAddr = '0;
		wValid = 1'b0;
		wData = '0;
		wStrb = '0;
		bReady = 1'b1;
		arValid = 1'b0;
		arAddr = '0;
		rReady = 1'b1;
		cpuBus = '0;
		cpuRfsh = 1'b0;
		download = '0;
		sdrReady = 1'b0;
		page2Addr = '0;
		page2Data = '0;

		wait (power === 1'b1);
		repeat (10) begin // SDRAM still training
			@(negedge clock32);
			checkValue("cpuReset_o", 1, cpuReset);
			checkValue("sdrReq_o.rd", 0, sdrReq.rd);
			checkValue("sdrReq_o.wr", 0, sdrReq.wr);
			checkValue("sdrReq_o.rfsh", 1, sdrReq.rfsh);
			checkValue("vmmWr_o", 0, vmmWr);
			checkValue("bValid_o", 0, bValid);
			checkValue("rValid_o", 0, rValid);
		end
		sdrReady = 1'b1;
		checkBoot();

		// Refresh follows the CPU once the copy is done
		cpuRfsh = 1'b1;
		@(negedge clock32);
		checkValue("sdrReq_o.rfsh", 1, sdrReq.rfsh);
		cpuRfsh = 1'b0;
		@(negedge clock32);
		checkValue("sdrReq_o.rfsh", 0, sdrReq.rfsh);

		// Registers, RAM size 64 KB and 8 MHz
		axiWrite(REG_CTRL, 32'h13, RESP_OKAY);
		axiRead(REG_CTRL, 32'h13, RESP_OKAY);
		checkValue("cpuSpeed_o", 1, cpuSpeed);
		axiRead(REG_STATUS, {16'd0, 8'd7, 5'd0, 3'b011}, RESP_OKAY);
		axiWrite(REG_STATUS, 32'hFFFF_FFFF, RESP_SLVERR);
		axiWrite(4'h8, 32'h1, RESP_SLVERR);
		axiRead(REG_STATUS, {16'd0, 8'd7, 5'd0, 3'b011}, RESP_OKAY);

		// Page F0 unpopulated, FC is RAM
		offs = randomOffset();
		cpuRead({8'hF0, offs}, 0, 8'hFF);
		value = randomByte();
		sdrMem[{2'b00, 8'hFC, offs}] = value;
		cpuRead({8'hFC, offs}, 1, value);

		// ROM download of pages 0 to 3
		download.active = 1'b1;
		@(negedge clock32);
		for (int page = 0; page < 4; page++) begin
			repeat (2) begin
				offs = randomOffset();
				value = randomByte();
				downloadByte({page[7:0], offs}, value);
				if (page == 2) begin
					page2Addr = {page[7:0], offs};
					page2Data = value;
				end
			end
		end
		download.active = 1'b0;
		repeat (2) @(negedge clock32);
		axiRead(REG_STATUS, {16'd0, 8'd3, 5'd0, 3'b011}, RESP_OKAY);
		cpuRead(page2Addr, 1, page2Data);
		waitReset(1'b0);

		// Write protection and video writes
		offs = randomOffset();
		cpuWrite({8'h02, offs}, randomByte(), 0, 0);
		cpuWrite({8'h07, 1'b1, offs[12:0]}, randomByte(), 1, 0);
		cpuWrite({8'hFC, offs}, randomByte(), 1, 1);

		// Soft reset
		axiWrite(REG_CTRL, 32'h113, RESP_OKAY);
		waitReset(1'b1);
		axiWrite(REG_CTRL, 32'h13, RESP_OKAY);
		waitReset(1'b0);

		$display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(Watchdog * 4);
		$display("Watchdog expired before the tests completed");
		$display("tests failed");
		$finish;
	end

endmodule

// ==== sim.f ====
memPkg.sv
memConfigRegs.sv
pageDecoder.sv
initLoader.sv
memArbiter.sv
memSubsystem.sv
tbClock.sv
tbMemSubsystem.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module tbMemSubsystem

obj_dir/simv: sim.f *.sv
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tbMemSubsystem -o simv --Mdir obj_dir

sim: obj_dir/simv
	./obj_dir/simv | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
